/* rtl/vchess_pkg.sv */
package vchess_pkg;

   localparam int EVAL_WIDTH = 16;
   localparam int RANK_SCORE_WIDTH = 14;

   // Piece kinds, code 7 scores as empty
   localparam logic [2:0] KIND_EMPTY  = 3'd0;
   localparam logic [2:0] KIND_PAWN   = 3'd1;
   localparam logic [2:0] KIND_KNIGHT = 3'd2;
   localparam logic [2:0] KIND_BISHOP = 3'd3;
   localparam logic [2:0] KIND_ROOK   = 3'd4;
   localparam logic [2:0] KIND_QUEEN  = 3'd5;
   localparam logic [2:0] KIND_KING   = 3'd6;

   // Material in centipawns
   localparam int VALUE_PAWN   = 100;
   localparam int VALUE_KNIGHT = 300;
   localparam int VALUE_BISHOP = 325;
   localparam int VALUE_ROOK   = 500;
   localparam int VALUE_QUEEN  = 900;
   localparam int VALUE_KING   = 0;

   // Bit positions in castle_mask
   localparam int CASTLE_WK = 3;   // White king side
   localparam int CASTLE_WQ = 2;
   localparam int CASTLE_BK = 1;
   localparam int CASTLE_BQ = 0;

   typedef struct packed {
      logic       black;
      logic [2:0] kind;
   } piece_t;

   typedef piece_t [7:0] rank_t;   // Index is the file, 0 is the a-file
   typedef rank_t [7:0] board_t;   // Index is the rank, 0 is White's back rank

   typedef enum logic [1:0] {
      write_square = 2'd0,
      set_state    = 2'd1,
      clear_board  = 2'd2,
      evaluate     = 2'd3
   } cmd_op_t;

   typedef struct packed {
      logic [5:0] index;   // Rank * 8 + file
      piece_t     piece;
   } square_write_t;

   typedef struct packed {
      logic       white_to_move;
      logic [3:0] castle_mask;
      logic [4:0] unused;
   } state_write_t;

   // Same ten bits, read per opcode
   typedef union packed {
      square_write_t square_w;
      state_write_t  state_w;
   } cmd_payload_u;

   typedef struct packed {
      cmd_op_t      op;
      cmd_payload_u payload;
   } host_cmd_t;

   typedef struct packed {
      board_t     board;
      logic       white_to_move;
      logic [3:0] castle_mask;
   } snapshot_t;

   typedef logic signed [EVAL_WIDTH-1:0] eval_t;
   typedef logic signed [RANK_SCORE_WIDTH-1:0] rank_score_t;

   // Unsigned material of one piece kind
   function automatic int piece_value(input logic [2:0] kind);
      case (kind)
         KIND_PAWN:   return VALUE_PAWN;
         KIND_KNIGHT: return VALUE_KNIGHT;
         KIND_BISHOP: return VALUE_BISHOP;
         KIND_ROOK:   return VALUE_ROOK;
         KIND_QUEEN:  return VALUE_QUEEN;
         KIND_KING:   return VALUE_KING;
         default:     return 0;   // Empty and the spare code
      endcase
   endfunction

endpackage

/* rtl/board_loader.sv */
module board_loader (
   input  logic                  clk,
   input  logic                  reset,
   input  vchess_pkg::host_cmd_t cmd,
   input  logic                  cmd_valid,
   output vchess_pkg::snapshot_t snapshot,
   output logic                  snap_valid
);
   import vchess_pkg::*;

   host_cmd_t     cmd_r;
   logic          cmd_valid_r;

   // Live position
   board_t        board;
   logic          white_to_move;
   logic [3:0]    castle_mask;

   square_write_t square_w;
   state_write_t  state_w;
   logic          take_snapshot;

   // Command strobe is registered before decode
   always_ff @(posedge clk)
   begin
      if (reset)
         cmd_valid_r <= 1'b0;
      else
         cmd_valid_r <= cmd_valid;
   end

   always_ff @(posedge clk)
   begin
      if (cmd_valid)
         cmd_r <= cmd;
   end

   // Two readings of the payload, opcode picks which one is acted on
   assign square_w = cmd_r.payload.square_w;
   assign state_w  = cmd_r.payload.state_w;

   assign take_snapshot = cmd_valid_r && (cmd_r.op == evaluate);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         board         <= '0;   // All squares empty
         white_to_move <= 1'b1;
         castle_mask   <= '0;
      end
      else if (cmd_valid_r)
      begin
         case (cmd_r.op)
            write_square:
            begin
               board[square_w.index[5:3]][square_w.index[2:0]] <= square_w.piece;
            end
            set_state:
            begin
               white_to_move <= state_w.white_to_move;
               castle_mask   <= state_w.castle_mask;
            end
            clear_board:
            begin
               board         <= '0;
               white_to_move <= 1'b1;
               castle_mask   <= '0;
            end
            default:
            begin
               // Evaluate leaves the position alone
            end
         endcase
      end
   end

   // Frozen copy for the scorers, later writes only touch the live board
   always_ff @(posedge clk)
   begin
      if (take_snapshot)
      begin
         snapshot.board         <= board;
         snapshot.white_to_move <= white_to_move;
         snapshot.castle_mask   <= castle_mask;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         snap_valid <= 1'b0;
      else
         snap_valid <= take_snapshot;   // One pulse per evaluate
   end

endmodule

/* rtl/rank_scorer.sv */
module rank_scorer #(
   parameter int RANK       = 0,
   parameter int PAWN_BONUS = 10
) (
   input  logic                    clk,
   input  logic                    reset,
   input  vchess_pkg::rank_t       rank_in,
   input  logic                    snap_valid,
   output vchess_pkg::rank_score_t rank_score
);
   import vchess_pkg::*;

   // Ranks advanced past the home rank, clamped at zero
   localparam int WHITE_STEPS = (RANK > 1) ? RANK - 1 : 0;
   localparam int BLACK_STEPS = (RANK < 6) ? 6 - RANK : 0;

   localparam int WHITE_PAWN_ADV = WHITE_STEPS * PAWN_BONUS;
   localparam int BLACK_PAWN_ADV = BLACK_STEPS * PAWN_BONUS;

   rank_score_t square_score [8];
   rank_score_t pair_sum [4];
   rank_score_t half_sum [2];
   rank_score_t score_next;

   // Signed worth of one square on this rank
   function automatic rank_score_t square_value(input piece_t p);
      int value;
      value = piece_value(p.kind);
      if (p.kind == KIND_PAWN)
         value = value + (p.black ? BLACK_PAWN_ADV : WHITE_PAWN_ADV);
      if (p.black)
         value = -value;   // Black counts against White
      return rank_score_t'(value);
   endfunction

   always_comb
   begin
      for (int f = 0; f < 8; f++)
         square_score[f] = square_value(rank_in[f]);
   end

   // Small adder tree over the eight files
   always_comb
   begin
      for (int p = 0; p < 4; p++)
         pair_sum[p] = square_score[2*p] + square_score[2*p+1];
   end

   always_comb
   begin
      half_sum[0] = pair_sum[0] + pair_sum[1];
      half_sum[1] = pair_sum[2] + pair_sum[3];
      score_next  = half_sum[0] + half_sum[1];
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         rank_score <= '0;
      else if (snap_valid)
         rank_score <= score_next;   // Holds between snapshots
   end

endmodule

/* rtl/eval_summer.sv */
module eval_summer #(
   parameter int CASTLE_BONUS = 15
) (
   input  logic                    clk,
   input  logic                    reset,
   input  vchess_pkg::rank_score_t rank_scores [8],
   input  logic                    snap_valid,
   input  logic                    white_to_move,
   input  logic [3:0]              castle_mask,
   output vchess_pkg::eval_t       eval,
   output logic                    eval_valid
);
   import vchess_pkg::*;

   // Side info delayed to meet the registered rank scores
   logic       score_valid;
   logic       score_white_to_move;
   logic [3:0] score_castle_mask;

   int         castle_count;
   eval_t      castle_term;
   eval_t      material_sum;
   eval_t      total;
   eval_t      signed_total;

   always_ff @(posedge clk)
   begin
      if (reset)
         score_valid <= 1'b0;
      else
         score_valid <= snap_valid;
   end

   always_ff @(posedge clk)
   begin
      score_white_to_move <= white_to_move;
      score_castle_mask   <= castle_mask;
   end

   // White rights held minus Black rights held
   always_comb
   begin
      castle_count = int'(score_castle_mask[CASTLE_WK]) + int'(score_castle_mask[CASTLE_WQ])
                   - int'(score_castle_mask[CASTLE_BK]) - int'(score_castle_mask[CASTLE_BQ]);
      castle_term  = eval_t'(castle_count * CASTLE_BONUS);
   end

   always_comb
   begin
      material_sum = '0;
      for (int r = 0; r < 8; r++)
         material_sum = material_sum + eval_t'(rank_scores[r]);   // Sign extends
   end

   assign total        = material_sum + castle_term;
   assign signed_total = score_white_to_move ? total : -total;   // Mover's view

   always_ff @(posedge clk)
   begin
      if (score_valid)
         eval <= signed_total;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         eval_valid <= 1'b0;
      else
         eval_valid <= score_valid;
   end

endmodule

/* rtl/vchess_eval_top.sv */
module vchess_eval_top #(
   parameter int PAWN_BONUS   = 10,
   parameter int CASTLE_BONUS = 15
) (
   input  logic                  clk,
   input  logic                  reset,
   input  vchess_pkg::host_cmd_t cmd,
   input  logic                  cmd_valid,
   output vchess_pkg::eval_t     eval,
   output logic                  eval_valid
);
   import vchess_pkg::*;

   snapshot_t   snapshot;
   logic        snap_valid;
   rank_score_t rank_scores [8];

   board_loader u_loader (
      .clk        (clk),
      .reset      (reset),
      .cmd        (cmd),
      .cmd_valid  (cmd_valid),
      .snapshot   (snapshot),
      .snap_valid (snap_valid)
   );

   // One scorer per rank, all working on the same snapshot
   for (genvar r = 0; r < 8; r++)
   begin : g_rank
      rank_scorer #(
         .RANK       (r),
         .PAWN_BONUS (PAWN_BONUS)
      ) u_scorer (
         .clk        (clk),
         .reset      (reset),
         .rank_in    (snapshot.board[r]),
         .snap_valid (snap_valid),
         .rank_score (rank_scores[r])
      );
   end

   eval_summer #(
      .CASTLE_BONUS (CASTLE_BONUS)
   ) u_summer (
      .clk           (clk),
      .reset         (reset),
      .rank_scores   (rank_scores),
      .snap_valid    (snap_valid),
      .white_to_move (snapshot.white_to_move),
      .castle_mask   (snapshot.castle_mask),
      .eval          (eval),
      .eval_valid    (eval_valid)
   );

endmodule

/* testbench/vchess_eval_chk.sv */
module vchess_eval_chk (
   input logic                  clk,
   input logic                  reset,
   input vchess_pkg::host_cmd_t cmd,
   input logic                  cmd_valid,
   input logic                  eval_valid
);
   timeunit 1ns;
   timeprecision 1ps;
   import vchess_pkg::*;

   int   assert_errors = 0;   // Read by the testbench summary
   logic evaluate_taken;

   assign evaluate_taken = cmd_valid && (cmd.op == evaluate);

   // Result loads three edges after the evaluate edge and is sampled high one edge later
   a_eval_latency: assert property (@(posedge clk) disable iff (reset)
      evaluate_taken |-> ##4 eval_valid)
   else
   begin
      $error("eval_valid missing three cycles after an evaluate command");
      assert_errors++;
   end

   a_no_spurious_eval: assert property (@(posedge clk) disable iff (reset)
      eval_valid |-> $past(evaluate_taken, 4))
   else
   begin
      $error("eval_valid high without an evaluate command three cycles earlier");
      assert_errors++;
   end

   a_quiet_in_reset: assert property (@(posedge clk)
      reset && $past(reset) |-> !eval_valid)
   else
   begin
      $error("eval_valid high while reset is held");
      assert_errors++;
   end

endmodule

bind vchess_eval_top vchess_eval_chk u_chk (
   .clk        (clk),
   .reset      (reset),
   .cmd        (cmd),
   .cmd_valid  (cmd_valid),
   .eval_valid (eval_valid)
);

/* testbench/vchess_eval_tb.sv */
module vchess_eval_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import vchess_pkg::*;

   localparam int CLK_PERIOD   = 10;
   localparam int PAWN_BONUS   = 10;   // Same as the DUT defaults
   localparam int CASTLE_BONUS = 15;
   localparam int DRAIN_LIMIT  = 10;   // Cycles allowed for results to come back

   // Command budget of each test, in run order
   localparam int TEST_CYCLES     = 12 + 40 + 72 + 116 + 44 + 760;
   localparam int MARGIN_CYCLES   = 200;   // Reset, drains and slack
   localparam int WATCHDOG_CYCLES = TEST_CYCLES + MARGIN_CYCLES;

   logic      clk;
   logic      reset;
   host_cmd_t cmd;
   logic      cmd_valid;
   eval_t     eval;
   logic      eval_valid;

   // Reference position, updated in command order
   piece_t     model_board [64];
   logic       model_white_to_move;
   logic [3:0] model_castle;

   int    exp_q [$];   // Expected scores of evaluations in flight
   int    due_q [$];   // Cycle on which each result must show up
   int    cycle = 0;
   int    error_count = 0;
   int    check_count = 0;
   int    tests_run = 0;
   int    test_errors;
   int    test_checks;
   string test_name = "reset";

   vchess_eval_top UUT (
      .clk        (clk),
      .reset      (reset),
      .cmd        (cmd),
      .cmd_valid  (cmd_valid),
      .eval       (eval),
      .eval_valid (eval_valid)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   always @(posedge clk)
      cycle <= cycle + 1;

   task automatic check_value(input string label, input int expected, input int actual);
      check_count++;
      if (expected != actual)
      begin
         $display("[FAIL] %s: expected %0d, actual %0d", label, expected, actual);
         error_count++;
      end
   endtask

   // Results are taken in the middle of the cycle, away from the clock edge
   always @(negedge clk)
   begin
      if (!reset && eval_valid)
      begin
         if (exp_q.size() == 0)
         begin
            $display("eval_valid rose at cycle %0d with no evaluation outstanding", cycle);
            error_count++;
         end
         else
         begin
            check_value(test_name, exp_q.pop_front(), int'(eval));
            check_value({test_name, " latency"}, due_q.pop_front(), cycle);
         end
      end
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
      $display("Testbench failed");
      $finish;
   end

   function automatic piece_t make_piece(input logic black, input logic [2:0] kind);
      piece_t p;
      p.black = black;
      p.kind  = kind;
      return p;
   endfunction

   // Score of the model position, seen from the side to move
   function automatic int expected_score();
      int total;
      int value;
      int r;
      piece_t p;
      total = 0;
      for (int sq = 0; sq < 64; sq++)
      begin
         p = model_board[sq];
         r = sq / 8;
         case (p.kind)
            KIND_PAWN:   value = VALUE_PAWN;
            KIND_KNIGHT: value = VALUE_KNIGHT;
            KIND_BISHOP: value = VALUE_BISHOP;
            KIND_ROOK:   value = VALUE_ROOK;
            KIND_QUEEN:  value = VALUE_QUEEN;
            default:     value = 0;   // King, empty and code 7
         endcase
         if (p.kind == KIND_PAWN && !p.black && r > 1)
            value = value + (r - 1) * PAWN_BONUS;
         if (p.kind == KIND_PAWN && p.black && r < 6)
            value = value + (6 - r) * PAWN_BONUS;
         total = p.black ? total - value : total + value;
      end
      total = total + CASTLE_BONUS * (int'(model_castle[3]) + int'(model_castle[2])
                                      - int'(model_castle[1]) - int'(model_castle[0]));
      if (!model_white_to_move)
         total = -total;
      return total;
   endfunction

   task automatic reset_model();
      foreach (model_board[i])
         model_board[i] = '0;
      model_white_to_move = 1'b1;
      model_castle        = 4'h0;
   endtask

   task automatic send_cmd(input host_cmd_t c);
      @(negedge clk);
      cmd       = c;
      cmd_valid = 1'b1;
   endtask

   task automatic put_piece(input int index, input piece_t p);
      host_cmd_t c;
      c = '0;
      c.op = write_square;
      c.payload.square_w.index = 6'(index);
      c.payload.square_w.piece = p;
      send_cmd(c);
      model_board[index] = p;
   endtask

   task automatic set_position_state(input logic white_to_move, input logic [3:0] mask);
      host_cmd_t c;
      c = '0;
      c.op = set_state;
      c.payload.state_w.white_to_move = white_to_move;
      c.payload.state_w.castle_mask   = mask;
      send_cmd(c);
      model_white_to_move = white_to_move;
      model_castle        = mask;
   endtask

   task automatic clear_position();
      host_cmd_t c;
      c = '0;
      c.op = clear_board;
      send_cmd(c);
      reset_model();
   endtask

   task automatic request_eval();
      host_cmd_t c;
      c = '0;
      c.op = evaluate;
      send_cmd(c);
      exp_q.push_back(expected_score());
      due_q.push_back(cycle + 4);   // Taken at the next edge, result 3 edges later
   endtask

   task automatic wait_results();
      int waited;
      waited = 0;
      @(negedge clk);
      cmd_valid = 1'b0;
      while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
      begin
         @(posedge clk);
         waited++;
      end
      if (exp_q.size() != 0)
      begin
         $display("Test %s: %0d evaluations never returned eval_valid", test_name, exp_q.size());
         error_count++;
         exp_q.delete();
         due_q.delete();
      end
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = error_count;
      test_checks = check_count;
   endtask

   task automatic end_test();
      wait_results();
      tests_run++;
      $display("Test %s finished: %0d checks, %0d errors", test_name,
               check_count - test_checks, error_count - test_errors);
   endtask

   task automatic test_reset_and_clear();
      begin_test("reset_clear");
      request_eval();   // Empty board straight out of reset
      put_piece(3, make_piece(1'b0, KIND_QUEEN));
      put_piece(56, make_piece(1'b1, KIND_ROOK));
      put_piece(28, make_piece(1'b0, KIND_PAWN));
      put_piece(62, make_piece(1'b1, KIND_KNIGHT));
      set_position_state(1'b0, 4'b1100);
      request_eval();
      clear_position();
      request_eval();
      end_test();
   endtask

   task automatic test_start_position();
      logic [2:0] back_row [8];
      back_row = '{KIND_ROOK, KIND_KNIGHT, KIND_BISHOP, KIND_QUEEN,
                   KIND_KING, KIND_BISHOP, KIND_KNIGHT, KIND_ROOK};
      begin_test("start_position");
      clear_position();
      for (int f = 0; f < 8; f++)
      begin
         put_piece(f, make_piece(1'b0, back_row[f]));
         put_piece(8 + f, make_piece(1'b0, KIND_PAWN));
         put_piece(48 + f, make_piece(1'b1, KIND_PAWN));
         put_piece(56 + f, make_piece(1'b1, back_row[f]));
      end
      set_position_state(1'b1, 4'hf);
      request_eval();
      set_position_state(1'b0, 4'hf);
      request_eval();
      end_test();
   endtask

   task automatic test_single_pieces();
      begin_test("single_pieces");
      for (int k = 1; k < 8; k++)
      begin
         for (int b = 0; b < 2; b++)
         begin
            clear_position();
            put_piece(27, make_piece(b[0], 3'(k)));   // d4
            request_eval();
            set_position_state(1'b0, 4'h0);
            request_eval();
         end
      end
      end_test();
   endtask

   task automatic test_pawns_and_castling();
      begin_test("pawns_castling");
      for (int r = 0; r < 8; r++)
      begin
         for (int b = 0; b < 2; b++)
         begin
            clear_position();
            put_piece(r * 8 + r, make_piece(b[0], KIND_PAWN));
            request_eval();
         end
      end
      clear_position();
      for (int m = 0; m < 16; m++)
      begin
         for (int s = 0; s < 2; s++)
         begin
            set_position_state(s[0], 4'(m));
            request_eval();
         end
      end
      end_test();
   endtask

   // No idle cycles, so evaluations overlap in the pipeline
   task automatic test_back_to_back();
      begin_test("back_to_back");
      clear_position();
      set_position_state(1'b1, 4'b1100);
      for (int i = 0; i < 12; i++)
      begin
         put_piece($urandom_range(63, 0),
                   make_piece(1'($urandom_range(1, 0)), 3'($urandom_range(7, 0))));
         request_eval();
         request_eval();
      end
      set_position_state(1'b0, 4'b0011);
      request_eval();
      request_eval();
      end_test();
   endtask

   // Sparse boards keep the total well inside 16 bits
   task automatic test_random_boards();
      begin_test("random_boards");
      for (int n = 0; n < 40; n++)
      begin
         clear_position();
         repeat (16)
            put_piece($urandom_range(63, 0),
                      make_piece(1'($urandom_range(1, 0)), 3'($urandom_range(7, 0))));
         set_position_state(1'($urandom_range(1, 0)), 4'($urandom_range(15, 0)));
         request_eval();
      end
      end_test();
   endtask

   initial
   begin
      void'($urandom(32'h12f69eba));
      clk       = 1'b0;
      reset     = 1'b1;
      cmd       = '0;
      cmd_valid = 1'b0;
      reset_model();
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      test_reset_and_clear();
      test_start_position();
      test_single_pieces();
      test_pawns_and_castling();
      test_back_to_back();
      test_random_boards();

      repeat (5) @(negedge clk);
      if (exp_q.size() != 0)
      begin
         $display("%0d expected results were left unchecked at the end", exp_q.size());
         error_count++;
      end
      $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
               tests_run, check_count, error_count, UUT.u_chk.assert_errors);
      if (error_count == 0 && UUT.u_chk.assert_errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

/* build.f */
rtl/vchess_pkg.sv
rtl/board_loader.sv
rtl/rank_scorer.sv
rtl/eval_summer.sv
rtl/vchess_eval_top.sv
testbench/vchess_eval_chk.sv
testbench/vchess_eval_tb.sv
